//--- basics_int.sv
`timescale 1ns/1ns

module basics_int (
	input  logic clk,
	input  logic arst_n,

	// Master bus
	input  logic [ice_pkg::byte_w-1:0] ma_addr,
	input  logic [ice_pkg::byte_w-1:0] ma_evt_id,
	input  logic ma_frame_valid,
	input  logic generate_nak,

	// Slave bus port
	output logic sl_arb_request,
	input  logic sl_arb_grant,
	output logic [ice_pkg::byte_w-1:0] dev_data,
	output logic dev_latch,
	output logic dev_tail
);

	import ice_pkg::*;

	logic frame_valid_q;
	logic frame_end;
	logic [byte_w-1:0] frame_cmd;
	logic [byte_w-1:0] frame_id;
	logic take;
	logic pend;
	logic is_nak;
	logic [byte_w-1:0] resp_id;
	logic [1:0] byte_cnt;
	logic [1:0] last_byte;

	assign frame_end = frame_valid_q && !ma_frame_valid;
	// Version query or NAK, unless another response is in flight
	assign take = frame_end && (generate_nak || (frame_cmd == cmd_version)) &&
		!(sl_arb_request && !dev_tail);

	// Command and id of the open frame
	always_ff @(posedge clk) begin
		if (ma_frame_valid) begin
			frame_cmd <= ma_addr;
			frame_id <= ma_evt_id;
		end
		if (take) begin
			is_nak <= generate_nak;
			resp_id <= frame_id;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_valid_q <= 1'b0;
			sl_arb_request <= 1'b0;
			pend <= 1'b0;
			byte_cnt <= '0;
		end else begin
			frame_valid_q <= ma_frame_valid;
			if (dev_latch) begin
				byte_cnt <= dev_tail ? '0 : byte_cnt + 1'b1;
			end
			// Request drops the cycle after the tail
			if (dev_tail) begin
				sl_arb_request <= 1'b0;
				pend <= 1'b0;
			end
			if (take) begin
				pend <= 1'b1;
			end
			if (!sl_arb_request && (pend || take)) begin
				sl_arb_request <= 1'b1;
			end
		end
	end

	// NAK is two bytes, version four
	assign last_byte = is_nak ? 2'd1 : 2'd3;
	assign dev_latch = sl_arb_request && sl_arb_grant;
	assign dev_tail = dev_latch && (byte_cnt == last_byte);

	always_comb begin
		case (byte_cnt)
			2'd0: dev_data = is_nak ? resp_nak : resp_version;
			2'd1: dev_data = resp_id;
			2'd2: dev_data = version_major;
			default: dev_data = version_minor;
		endcase
	end

endmodule

//--- flist.f
ice_pkg.sv
ice_bus_controller.sv
slave_bus_arbiter.sv
basics_int.sv
gpio_int.sv
ice_bus_top.sv
ice_bus_assert.sv
tb_ice_bus.sv

//--- gpio_int.sv
`timescale 1ns/1ns

module gpio_int #(
	parameter int GPIO_W = 8
) (
	input  logic clk,
	input  logic arst_n,

	// Pins and pin control
	input  logic [GPIO_W-1:0] gpio_in,
	output logic [GPIO_W-1:0] gpio_level,
	output logic [GPIO_W-1:0] gpio_direction,
	output logic gpio_int_enable_hit,

	// Master bus
	input  logic [ice_pkg::byte_w-1:0] ma_addr,
	input  logic [ice_pkg::byte_w-1:0] ma_evt_id,
	input  logic [ice_pkg::byte_w-1:0] ma_data,
	input  logic ma_data_valid,
	input  logic ma_frame_valid,
	input  logic [ice_pkg::byte_w-1:0] global_counter,

	// Slave bus port
	output logic sl_arb_request,
	input  logic sl_arb_grant,
	output logic [ice_pkg::byte_w-1:0] dev_data,
	output logic dev_latch,
	output logic dev_tail
);

	import ice_pkg::*;

	logic frame_valid_q;
	logic frame_end;
	logic [byte_w-1:0] frame_cmd;
	logic [byte_w-1:0] frame_id;
	logic [1:0] pay_idx;
	logic [GPIO_W-1:0] int_enable;
	logic [GPIO_W-1:0] gpio_q;
	logic [GPIO_W-1:0] rise;
	logic cmd_take;
	logic cmd_pend;
	logic evt_pend;
	logic cmd_is_read;
	logic [byte_w-1:0] cmd_id;
	logic [byte_w-1:0] cmd_val;
	logic [byte_w-1:0] evt_stamp;
	logic [byte_w-1:0] evt_val;
	logic send_evt;
	logic [1:0] byte_cnt;
	logic [1:0] last_byte;
	logic start_cmd;
	logic start_evt;

	assign frame_end = frame_valid_q && !ma_frame_valid;
	// Dropped only while a command frame is still being sent
	assign cmd_take = frame_end &&
		((frame_cmd == cmd_gpio_cfg) || (frame_cmd == cmd_gpio_read)) &&
		!(sl_arb_request && !send_evt && !dev_tail);

	// Edges on enabled pins; one event outstanding at a time
	assign rise = gpio_in & ~gpio_q & int_enable;
	assign gpio_int_enable_hit = (|rise) && !evt_pend;

	// Command responses go before events
	assign start_cmd = !sl_arb_request && (cmd_pend || cmd_take);
	assign start_evt = !sl_arb_request && !start_cmd && (evt_pend || gpio_int_enable_hit);

	always_ff @(posedge clk) begin
		if (ma_frame_valid) begin
			frame_cmd <= ma_addr;
			frame_id <= ma_evt_id;
		end
		if (cmd_take) begin
			cmd_is_read <= (frame_cmd == cmd_gpio_read);
			cmd_id <= frame_id;
			cmd_val <= byte_w'(gpio_in);
		end
		// Stamp with the counter value after this increment
		if (gpio_int_enable_hit) begin
			evt_stamp <= global_counter + 1'b1;
			evt_val <= byte_w'(gpio_in);
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			frame_valid_q <= 1'b0;
			pay_idx <= '0;
			gpio_level <= '0;
			gpio_direction <= '0;
			int_enable <= '0;
			gpio_q <= '0;
			cmd_pend <= 1'b0;
			evt_pend <= 1'b0;
			send_evt <= 1'b0;
			sl_arb_request <= 1'b0;
			byte_cnt <= '0;
		end else begin
			frame_valid_q <= ma_frame_valid;
			gpio_q <= gpio_in;
			// Payload bytes: level, direction, interrupt enable
			if (!ma_frame_valid) begin
				pay_idx <= '0;
			end else if (ma_data_valid && (pay_idx != 2'd3)) begin
				pay_idx <= pay_idx + 1'b1;
			end
			if (ma_data_valid && (ma_addr == cmd_gpio_cfg)) begin
				case (pay_idx)
					2'd0: gpio_level <= GPIO_W'(ma_data);
					2'd1: gpio_direction <= GPIO_W'(ma_data);
					2'd2: int_enable <= GPIO_W'(ma_data);
					default: ;
				endcase
			end
			if (dev_latch) begin
				byte_cnt <= dev_tail ? '0 : byte_cnt + 1'b1;
			end
			if (dev_tail) begin
				sl_arb_request <= 1'b0;
				if (send_evt) begin
					evt_pend <= 1'b0;
				end else begin
					cmd_pend <= 1'b0;
				end
			end
			// Sets after the tail clear so a new one survives
			if (cmd_take) begin
				cmd_pend <= 1'b1;
			end
			if (gpio_int_enable_hit) begin
				evt_pend <= 1'b1;
			end
			if (start_cmd || start_evt) begin
				sl_arb_request <= 1'b1;
				send_evt <= start_evt;
			end
		end
	end

	// Ack is two bytes, read and event three
	assign last_byte = (!send_evt && !cmd_is_read) ? 2'd1 : 2'd2;
	assign dev_latch = sl_arb_request && sl_arb_grant;
	assign dev_tail = dev_latch && (byte_cnt == last_byte);

	always_comb begin
		case (byte_cnt)
			2'd0: dev_data = send_evt ? resp_gpio_event :
				(cmd_is_read ? resp_gpio_read : resp_ack);
			2'd1: dev_data = send_evt ? evt_stamp : cmd_id;
			default: dev_data = send_evt ? evt_val : cmd_val;
		endcase
	end

endmodule

//--- ice_bus_assert.sv
`timescale 1ns/1ns

module ice_bus_assert #(
	parameter int NUM_DEV = 2
) (
	input  logic clk,
	input  logic arst_n,
	input  logic [NUM_DEV-1:0] sl_arb_request,
	input  logic [NUM_DEV-1:0] sl_arb_grant,
	input  logic sl_hold,
	input  logic tx_char_valid,
	input  logic tx_char_ready
);

	// At most one peer owns the slave bus
	a_grant_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(sl_arb_grant))
		else $error("Slave bus grant not one-hot: %b", sl_arb_grant);

	// Fresh grant bit only where a request stood the cycle before
	a_grant_to_requester: assert property (@(posedge clk) disable iff (!arst_n)
		((sl_arb_grant & ~$past(sl_arb_grant) & ~$past(sl_arb_request)) == '0))
		else $error("Grant %b given to a peer that was not requesting", sl_arb_grant);

	// Idle bus stays idle while the FIFO is short of room
	a_hold_blocks_grant: assert property (@(posedge clk) disable iff (!arst_n)
		($past(sl_hold) && ($past(sl_arb_grant) == '0)) |-> (sl_arb_grant == '0))
		else $error("New grant %b started while sl_hold was high", sl_arb_grant);

	// Host byte strobe only while the host accepts
	a_tx_with_ready: assert property (@(posedge clk) disable iff (!arst_n)
		tx_char_valid |-> tx_char_ready)
		else $error("tx_char_valid high while tx_char_ready low");

endmodule

//--- ice_bus_controller.sv
`timescale 1ns/1ns

module ice_bus_controller #(
	parameter int NUM_DEV = 2,
	parameter int RESP_FIFO_DEPTH = 16
) (
	input  logic clk,
	input  logic arst_n,

	// Host byte stream
	input  logic [ice_pkg::byte_w-1:0] rx_char,
	input  logic rx_char_valid,
	output logic [ice_pkg::byte_w-1:0] tx_char,
	output logic tx_char_valid,
	input  logic tx_char_ready,

	// Master bus toward all peers
	output logic [ice_pkg::byte_w-1:0] ma_addr,
	output logic [ice_pkg::byte_w-1:0] ma_evt_id,
	output logic [ice_pkg::byte_w-1:0] ma_data,
	output logic ma_data_valid,
	output logic ma_frame_valid,
	output logic generate_nak,

	// Arbitrated slave bus
	input  logic [ice_pkg::byte_w-1:0] sl_data,
	input  logic sl_latch,
	input  logic sl_tail,
	output logic sl_hold,

	// Time tagging
	input  logic ctr_incr,
	output logic [ice_pkg::byte_w-1:0] global_counter
);

	import ice_pkg::*;

	// Parser states, in frame byte order
	localparam logic [1:0] st_cmd = 2'd0;
	localparam logic [1:0] st_id = 2'd1;
	localparam logic [1:0] st_len = 2'd2;
	localparam logic [1:0] st_payload = 2'd3;

	localparam int ptr_w = (RESP_FIFO_DEPTH > 1) ? $clog2(RESP_FIFO_DEPTH) : 1;
	localparam int cnt_w = $clog2(RESP_FIFO_DEPTH + 1);
	// Fill level above which a longest response may not fit
	localparam logic [cnt_w-1:0] hold_level = cnt_w'(RESP_FIFO_DEPTH - max_resp_len);
	localparam logic [cnt_w-1:0] full_level = cnt_w'(RESP_FIFO_DEPTH);
	localparam int min_depth = NUM_DEV * max_resp_len;

	logic [1:0] state;
	logic [byte_w-1:0] len_left;
	logic end_pend;
	logic nak_pend;
	logic claimed;

	logic [byte_w-1:0] fifo_mem [RESP_FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] fifo_cnt;
	logic fifo_wr;
	logic fifo_rd;
	logic in_frame;

	// Room for one full response per peer
	if (RESP_FIFO_DEPTH < min_depth) begin : g_depth_check
		$error("Response FIFO too shallow for %0d peers", NUM_DEV);
	end

	// Some peer answers this command
	assign claimed = (ma_addr == cmd_version) || (ma_addr == cmd_gpio_cfg) ||
		(ma_addr == cmd_gpio_read);

	// Frame parser control
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= st_cmd;
			len_left <= '0;
			end_pend <= 1'b0;
			nak_pend <= 1'b0;
			ma_data_valid <= 1'b0;
			ma_frame_valid <= 1'b0;
			generate_nak <= 1'b0;
		end else begin
			ma_data_valid <= 1'b0;
			generate_nak <= 1'b0;
			// Frame end, one cycle after the last byte
			if (end_pend) begin
				end_pend <= 1'b0;
				ma_frame_valid <= 1'b0;
				generate_nak <= nak_pend;
			end
			if (rx_char_valid) begin
				case (state)
					st_cmd: state <= st_id;
					st_id: state <= st_len;
					st_len: begin
						ma_frame_valid <= 1'b1;
						nak_pend <= !claimed;
						len_left <= rx_char;
						// Empty frame ends right away
						if (rx_char == '0) begin
							end_pend <= 1'b1;
							state <= st_cmd;
						end else begin
							state <= st_payload;
						end
					end
					default: begin
						ma_data_valid <= 1'b1;
						len_left <= len_left - 1'b1;
						if (len_left == 8'd1) begin
							end_pend <= 1'b1;
							state <= st_cmd;
						end
					end
				endcase
			end
		end
	end

	// Master bus fields
	always_ff @(posedge clk) begin
		if (rx_char_valid) begin
			case (state)
				st_cmd: ma_addr <= rx_char;
				st_id: ma_evt_id <= rx_char;
				st_payload: ma_data <= rx_char;
				default: ;
			endcase
		end
	end

	// Response FIFO, drained straight to the host
	assign fifo_wr = sl_latch && (fifo_cnt != full_level);
	assign fifo_rd = tx_char_ready && (fifo_cnt != '0);
	assign tx_char_valid = fifo_rd;
	assign tx_char = fifo_mem[rd_ptr];
	// No new grant while space is short or a frame is still arriving
	assign sl_hold = in_frame || (fifo_cnt > hold_level);

	always_ff @(posedge clk) begin
		if (fifo_wr) begin
			fifo_mem[wr_ptr] <= sl_data;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fifo_cnt <= '0;
			in_frame <= 1'b0;
		end else begin
			if (fifo_wr) begin
				wr_ptr <= (wr_ptr == ptr_w'(RESP_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (fifo_rd) begin
				rd_ptr <= (rd_ptr == ptr_w'(RESP_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({fifo_wr, fifo_rd})
				2'b10: fifo_cnt <= fifo_cnt + 1'b1;
				2'b01: fifo_cnt <= fifo_cnt - 1'b1;
				default: ;
			endcase
			// Open from first byte until the tail byte
			if (sl_latch) begin
				in_frame <= !sl_tail;
			end
		end
	end

	// Global event counter, wraps
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			global_counter <= '0;
		end else if (ctr_incr) begin
			global_counter <= global_counter + 1'b1;
		end
	end

endmodule

//--- ice_bus_top.sv
`timescale 1ns/1ns

module ice_bus_top #(
	parameter int NUM_DEV = 2,
	parameter int RESP_FIFO_DEPTH = 16,
	parameter int GPIO_W = 8
) (
	input  logic clk,
	input  logic arst_n,

	input  logic [ice_pkg::byte_w-1:0] rx_char,
	input  logic rx_char_valid,
	output logic [ice_pkg::byte_w-1:0] tx_char,
	output logic tx_char_valid,
	input  logic tx_char_ready,

	input  logic [GPIO_W-1:0] gpio_in,
	output logic [GPIO_W-1:0] gpio_level,
	output logic [GPIO_W-1:0] gpio_direction
);

	import ice_pkg::*;

	// Master bus
	logic [byte_w-1:0] ma_addr;
	logic [byte_w-1:0] ma_evt_id;
	logic [byte_w-1:0] ma_data;
	logic ma_data_valid;
	logic ma_frame_valid;
	logic generate_nak;

	// Slave bus
	logic [NUM_DEV-1:0] sl_arb_request;
	logic [NUM_DEV-1:0] sl_arb_grant;
	logic [NUM_DEV-1:0][byte_w-1:0] dev_data;
	logic [NUM_DEV-1:0] dev_latch;
	logic [NUM_DEV-1:0] dev_tail;
	logic [byte_w-1:0] sl_data;
	logic sl_latch;
	logic sl_tail;
	logic sl_hold;

	// Event time tags
	logic ctr_incr;
	logic [byte_w-1:0] global_counter;

	ice_bus_controller #(
		.NUM_DEV(NUM_DEV),
		.RESP_FIFO_DEPTH(RESP_FIFO_DEPTH)
	) ctrl0 (
		.clk(clk),
		.arst_n(arst_n),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.tx_char(tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready),
		.ma_addr(ma_addr),
		.ma_evt_id(ma_evt_id),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.generate_nak(generate_nak),
		.sl_data(sl_data),
		.sl_latch(sl_latch),
		.sl_tail(sl_tail),
		.sl_hold(sl_hold),
		.ctr_incr(ctr_incr),
		.global_counter(global_counter)
	);

	slave_bus_arbiter #(
		.NUM_DEV(NUM_DEV)
	) arb0 (
		.clk(clk),
		.arst_n(arst_n),
		.sl_arb_request(sl_arb_request),
		.sl_arb_grant(sl_arb_grant),
		.dev_data(dev_data),
		.dev_latch(dev_latch),
		.dev_tail(dev_tail),
		.sl_hold(sl_hold),
		.sl_data(sl_data),
		.sl_latch(sl_latch),
		.sl_tail(sl_tail)
	);

	// Device 0, version and NAK responder
	basics_int bi0 (
		.clk(clk),
		.arst_n(arst_n),
		.ma_addr(ma_addr),
		.ma_evt_id(ma_evt_id),
		.ma_frame_valid(ma_frame_valid),
		.generate_nak(generate_nak),
		.sl_arb_request(sl_arb_request[0]),
		.sl_arb_grant(sl_arb_grant[0]),
		.dev_data(dev_data[0]),
		.dev_latch(dev_latch[0]),
		.dev_tail(dev_tail[0])
	);

	// Device 1, GPIO
	gpio_int #(
		.GPIO_W(GPIO_W)
	) gi1 (
		.clk(clk),
		.arst_n(arst_n),
		.gpio_in(gpio_in),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction),
		.gpio_int_enable_hit(ctr_incr),
		.ma_addr(ma_addr),
		.ma_evt_id(ma_evt_id),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.global_counter(global_counter),
		.sl_arb_request(sl_arb_request[1]),
		.sl_arb_grant(sl_arb_grant[1]),
		.dev_data(dev_data[1]),
		.dev_latch(dev_latch[1]),
		.dev_tail(dev_tail[1])
	);

	// Slots beyond the two peers stay silent
	for (genvar i = 2; i < NUM_DEV; i++) begin : g_unused_dev
		assign sl_arb_request[i] = 1'b0;
		assign dev_data[i] = '0;
		assign dev_latch[i] = 1'b0;
		assign dev_tail[i] = 1'b0;
	end

endmodule

//--- ice_pkg.sv
package ice_pkg;

	// Width of every host character and bus byte
	localparam int byte_w = 8;

	// Command codes claimed by a peer
	// 'V'
	localparam logic [byte_w-1:0] cmd_version = 8'h56;
	// 'G'
	localparam logic [byte_w-1:0] cmd_gpio_cfg = 8'h47;
	// 'r'
	localparam logic [byte_w-1:0] cmd_gpio_read = 8'h72;

	// First byte of each response frame
	// '/'
	localparam logic [byte_w-1:0] resp_ack = 8'h2f;
	// '~'
	localparam logic [byte_w-1:0] resp_nak = 8'h7e;
	// 'V'
	localparam logic [byte_w-1:0] resp_version = 8'h56;
	// 'r'
	localparam logic [byte_w-1:0] resp_gpio_read = 8'h72;
	// 'g'
	localparam logic [byte_w-1:0] resp_gpio_event = 8'h67;

	// Longest response frame, code byte included
	localparam int max_resp_len = 4;

	// Revision reported by the basics peer
	localparam logic [byte_w-1:0] version_major = 8'h02;
	localparam logic [byte_w-1:0] version_minor = 8'h05;

endpackage

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_ice_bus -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_ice_bus 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -q "^Testbench passed$"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- slave_bus_arbiter.sv
`timescale 1ns/1ns

module slave_bus_arbiter #(
	parameter int NUM_DEV = 2
) (
	input  logic clk,
	input  logic arst_n,

	input  logic [NUM_DEV-1:0] sl_arb_request,
	output logic [NUM_DEV-1:0] sl_arb_grant,

	// Per-peer byte ports
	input  logic [NUM_DEV-1:0][ice_pkg::byte_w-1:0] dev_data,
	input  logic [NUM_DEV-1:0] dev_latch,
	input  logic [NUM_DEV-1:0] dev_tail,

	input  logic sl_hold,

	// Shared bus toward the controller
	output logic [ice_pkg::byte_w-1:0] sl_data,
	output logic sl_latch,
	output logic sl_tail
);

	localparam int idx_w = (NUM_DEV > 1) ? $clog2(NUM_DEV) : 1;

	logic [idx_w-1:0] last_idx;
	logic [idx_w-1:0] pick_idx;
	logic bus_busy;
	logic grant_kept;

	assign bus_busy = |sl_arb_grant;
	// Granted peer still wants the bus
	assign grant_kept = |(sl_arb_grant & sl_arb_request);

	// Nearest requester after the last granted one
	always_comb begin
		int cand;
		pick_idx = last_idx;
		// Walk far to near so the nearest wins
		for (int i = NUM_DEV; i >= 1; i--) begin
			cand = (int'(last_idx) + i) % NUM_DEV;
			if (sl_arb_request[cand]) begin
				pick_idx = idx_w'(cand);
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sl_arb_grant <= '0;
			// Device 0 comes first after reset
			last_idx <= idx_w'(NUM_DEV - 1);
		end else if (bus_busy) begin
			// Grant held until the request drops
			if (!grant_kept) begin
				sl_arb_grant <= '0;
			end
		end else if (!sl_hold && (|sl_arb_request)) begin
			sl_arb_grant <= NUM_DEV'(1) << pick_idx;
			last_idx <= pick_idx;
		end
	end

	// Mux the granted peer onto the bus
	always_comb begin
		sl_data = '0;
		sl_latch = 1'b0;
		sl_tail = 1'b0;
		for (int i = 0; i < NUM_DEV; i++) begin
			if (sl_arb_grant[i]) begin
				sl_data = sl_data | dev_data[i];
				sl_latch = sl_latch | dev_latch[i];
				sl_tail = sl_tail | dev_tail[i];
			end
		end
	end

endmodule

//--- tb_ice_bus.sv
`timescale 1ns/1ns

module tb_ice_bus;

	import ice_pkg::*;

	// About a dozen frames and events, each well under a hundred cycles with random stalls
	localparam int cycle_limit = 4000;

	logic clk;
	logic arst_n;
	logic [byte_w-1:0] rx_char;
	logic rx_char_valid;
	logic [byte_w-1:0] tx_char;
	logic tx_char_valid;
	logic tx_char_ready;
	logic [7:0] gpio_in;
	logic [7:0] gpio_level;
	logic [7:0] gpio_direction;

	// Response bytes still owed to the host, oldest first
	logic [byte_w-1:0] exp_q[$];
	logic [31:0] rdy_state;
	logic [31:0] data_state;
	// Host refuses every byte while set
	logic host_stall;
	int cycle_cnt;
	int evt_count;

	ice_bus_top #(
		.NUM_DEV(2),
		.RESP_FIFO_DEPTH(16),
		.GPIO_W(8)
	) dut (
		.clk(clk),
		.arst_n(arst_n),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.tx_char(tx_char),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready),
		.gpio_in(gpio_in),
		.gpio_level(gpio_level),
		.gpio_direction(gpio_direction)
	);

	// Arbitration checks, tx side unused here
	bind slave_bus_arbiter ice_bus_assert #(.NUM_DEV(NUM_DEV)) arb_checks (
		.clk(clk),
		.arst_n(arst_n),
		.sl_arb_request(sl_arb_request),
		.sl_arb_grant(sl_arb_grant),
		.sl_hold(sl_hold),
		.tx_char_valid(1'b0),
		.tx_char_ready(1'b1)
	);

	// Host-side check only; grants tied idle
	bind ice_bus_controller ice_bus_assert #(.NUM_DEV(NUM_DEV)) ctrl_checks (
		.clk(clk),
		.arst_n(arst_n),
		.sl_arb_request('0),
		.sl_arb_grant('0),
		.sl_hold(sl_hold),
		.tx_char_valid(tx_char_valid),
		.tx_char_ready(tx_char_ready)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [7:0] rand_byte();
		data_state = xorshift(data_state);
		return data_state[7:0];
	endfunction

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1);
	endtask

	// One byte per cycle; strobe stays high until rx_idle
	task automatic send_byte(input logic [7:0] b);
		@(posedge clk);
		rx_char <= b;
		rx_char_valid <= 1'b1;
	endtask

	task automatic send_frame(input logic [7:0] cmd, input logic [7:0] id,
		input logic [7:0] len, input logic [7:0] p0, input logic [7:0] p1,
		input logic [7:0] p2);
		send_byte(cmd);
		send_byte(id);
		send_byte(len);
		if (len > 8'd0) begin
			send_byte(p0);
		end
		if (len > 8'd1) begin
			send_byte(p1);
		end
		if (len > 8'd2) begin
			send_byte(p2);
		end
	endtask

	task automatic rx_idle();
		@(posedge clk);
		rx_char_valid <= 1'b0;
	endtask

	task automatic set_pins(input logic [7:0] v);
		@(posedge clk);
		gpio_in <= v;
	endtask

	// Until every owed byte is out, then a quiet window for strays
	task automatic wait_drain();
		while (exp_q.size() != 0) begin
			@(posedge clk);
		end
		repeat (20) @(posedge clk);
	endtask

	task automatic expect_version(input logic [7:0] id);
		exp_q.push_back(resp_version);
		exp_q.push_back(id);
		exp_q.push_back(version_major);
		exp_q.push_back(version_minor);
	endtask

	task automatic expect_read(input logic [7:0] id, input logic [7:0] pins);
		exp_q.push_back(resp_gpio_read);
		exp_q.push_back(id);
		exp_q.push_back(pins);
	endtask

	task automatic expect_event(input logic [7:0] pins);
		evt_count++;
		exp_q.push_back(resp_gpio_event);
		exp_q.push_back(evt_count[7:0]);
		exp_q.push_back(pins);
	endtask

	// Random host back-pressure
	always @(posedge clk) begin
		rdy_state = xorshift(rdy_state);
		tx_char_ready <= rdy_state[7] && !host_stall;
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			abort_run($sformatf("Timeout: test not finished after %0d cycles", cycle_limit));
		end
	end

	// Mid-cycle, tx strobe and byte are settled
	always @(negedge clk) begin
		if (arst_n && tx_char_valid) begin
			assert (exp_q.size() != 0) begin
				assert (tx_char == exp_q[0]) exp_q.delete(0);
				else abort_run($sformatf("Fail at %0t ns: tx_char %h, expected %h",
					$time, tx_char, exp_q[0]));
			end else begin
				abort_run("Host byte sent while no response byte was expected");
			end
		end
	end

	initial begin
		logic [7:0] id;
		logic [7:0] id2;
		logic [7:0] lvl;
		logic [7:0] dir;
		logic [7:0] pins;
		clk = 1'b0;
		arst_n = 1'b0;
		rx_char = '0;
		rx_char_valid = 1'b0;
		tx_char_ready = 1'b0;
		gpio_in = '0;
		rdy_state = 32'd14;
		data_state = 32'd14;
		host_stall = 1'b0;
		cycle_cnt = 0;
		evt_count = 0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) @(posedge clk);

		// Version query, empty payload
		id = rand_byte();
		expect_version(id);
		send_frame(cmd_version, id, 8'd0, 8'h00, 8'h00, 8'h00);
		rx_idle();
		wait_drain();

		// 'Q' is claimed by nobody
		id = rand_byte();
		exp_q.push_back(resp_nak);
		exp_q.push_back(id);
		send_frame(8'h51, id, 8'd2, rand_byte(), rand_byte(), 8'h00);
		rx_idle();
		wait_drain();

		// Level, direction, enable for pins 3..0
		id = rand_byte();
		lvl = rand_byte();
		dir = rand_byte();
		exp_q.push_back(resp_ack);
		exp_q.push_back(id);
		send_frame(cmd_gpio_cfg, id, 8'd3, lvl, dir, 8'h0f);
		rx_idle();
		wait_drain();
		assert ((gpio_level == lvl) && (gpio_direction == dir))
		else abort_run($sformatf("Fail at %0t ns: level %h dir %h, expected %h %h",
			$time, gpio_level, gpio_direction, lvl, dir));

		// Enabled edges, one event per change
		expect_event(8'h01);
		set_pins(8'h01);
		wait_drain();
		set_pins(8'h00);
		expect_event(8'h05);
		set_pins(8'h05);
		wait_drain();
		set_pins(8'h00);

		// Only disabled pins rise, so silence
		pins = 8'h80 | (rand_byte() & 8'h70);
		set_pins(pins);
		wait_drain();

		id = rand_byte();
		expect_read(id, pins);
		send_frame(cmd_gpio_read, id, 8'd0, 8'h00, 8'h00, 8'h00);
		rx_idle();
		wait_drain();

		// Two frames with no gap between them
		id = rand_byte();
		id2 = rand_byte();
		expect_version(id);
		expect_read(id2, pins);
		send_frame(cmd_version, id, 8'd0, 8'h00, 8'h00, 8'h00);
		send_frame(cmd_gpio_read, id2, 8'd0, 8'h00, 8'h00, 8'h00);
		rx_idle();
		wait_drain();

		// Host stalled, four version answers fill the FIFO past the hold level
		host_stall <= 1'b1;
		repeat (4) begin
			id = rand_byte();
			expect_version(id);
			send_frame(cmd_version, id, 8'd3, 8'h00, 8'h00, 8'h00);
			rx_idle();
		end
		// Read answer waits for FIFO room
		id2 = rand_byte();
		expect_read(id2, pins);
		send_frame(cmd_gpio_read, id2, 8'd0, 8'h00, 8'h00, 8'h00);
		rx_idle();
		repeat (30) @(posedge clk);
		host_stall <= 1'b0;
		wait_drain();

		if (exp_q.size() == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			abort_run("Response bytes still outstanding at end of test");
		end
	end

endmodule
